//--- Bender.yml
package:
  name: ex_stage

sources:
  - isa_pkg.sv
  - ex_pkg.sv
  - operand_select.sv
  - int_alu.sv
  - branch_resolve.sv
  - mult_pipeline.sv
  - completion_buffer.sv
  - ex_control.sv
  - ex_stage.sv
  - target: test
    files:
      - ex_stage_assertions.sv
      - tb_ex_stage.sv

//--- branch_resolve.sv
// branch resolution
// evaluates the condition, picks the target and flags
// a misprediction against the issuer's guess
module branch_resolve (
	input  ex_pkg::issue_pkt_t       issue_pkt,
	input  logic [ex_pkg::XLEN-1:0]  alu_result,
	output ex_pkg::branch_rec_t      branch
);
	import ex_pkg::*;
	import isa_pkg::*;

	logic signed [XLEN-1:0] srs1;
	logic signed [XLEN-1:0] srs2;
	logic                   cond;

	assign srs1 = issue_pkt.rs1_value;
	assign srs2 = issue_pkt.rs2_value;

	always_comb begin
		case (issue_pkt.inst.b.funct3)
			BR_BEQ:  cond = issue_pkt.rs1_value == issue_pkt.rs2_value;
			BR_BNE:  cond = issue_pkt.rs1_value != issue_pkt.rs2_value;
			BR_BLT:  cond = srs1 < srs2;
			BR_BGE:  cond = srs1 >= srs2;
			BR_BLTU: cond = issue_pkt.rs1_value < issue_pkt.rs2_value;
			BR_BGEU: cond = issue_pkt.rs1_value >= issue_pkt.rs2_value;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		branch.tag = issue_pkt.tag;
		if (issue_pkt.uncond_branch) begin
			// jumps always go; compare against the predicted target
			branch.taken      = 1'b1;
			branch.target     = alu_result;
			branch.mispredict = alu_result != issue_pkt.predicted_target;
		end else begin
			branch.taken      = cond;
			branch.target     = cond ? alu_result : issue_pkt.npc;
			branch.mispredict = issue_pkt.predicted_taken ^ cond;
		end
	end

endmodule

//--- completion_buffer.sv
// completion buffer
// circular queue of finished results; two writes and
// one read per cycle, port a written ahead of port b
module completion_buffer (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            wr_a,
	input  ex_pkg::result_t data_a,
	input  logic            wr_b,
	input  ex_pkg::result_t data_b,
	input  logic            pop,
	output logic            head_valid,
	output ex_pkg::result_t head
);
	import ex_pkg::*;

	result_t                      mem [BUF_DEPTH];
	logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
	logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
	logic [$clog2(BUF_DEPTH)-1:0] wr_ptr_b;
	logic [CNT_W-1:0]             count;

	// port b lands behind port a when both write
	assign wr_ptr_b = wr_ptr + {{($clog2(BUF_DEPTH)-1){1'b0}}, wr_a};

	always_ff @(posedge clock) begin
		if (wr_a) begin
			mem[wr_ptr] <= data_a;
		end
		if (wr_b) begin
			mem[wr_ptr_b] <= data_b;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + {{($clog2(BUF_DEPTH)-2){1'b0}}, {1'b0, wr_a} + {1'b0, wr_b}};
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + {{(CNT_W-1){1'b0}}, wr_a} + {{(CNT_W-1){1'b0}}, wr_b}
				- {{(CNT_W-1){1'b0}}, pop};
		end
	end

	assign head_valid = count != '0;
	assign head       = mem[rd_ptr];

endmodule

//--- ex_control.sv
// execute stage control
// registers the ALU result, orders it behind a multiply
// finishing in the same cycle, keeps the bus credits and
// drains the buffer onto the result bus
module ex_control (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            issue_valid,
	input  logic            issue_is_mult,
	input  logic            alu_done,
	input  ex_pkg::result_t alu_result,
	input  logic            mult_done,
	input  ex_pkg::result_t mult_result,
	input  logic            head_valid,
	input  logic            bus_credit,
	output logic            wr_a,
	output ex_pkg::result_t data_a,
	output logic            wr_b,
	output ex_pkg::result_t data_b,
	output logic            pop,
	output logic            issue_credit,
	output logic            complete_valid
);
	import ex_pkg::*;

	logic             alu_q_valid;
	result_t          alu_q;
	logic [CNT_W-1:0] bus_cnt;

	////////////////////////////////////////
	// non-multiply result register
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			alu_q_valid <= 1'b0;
		end else begin
			alu_q_valid <= issue_valid && !issue_is_mult;
		end
	end

	always_ff @(posedge clock) begin
		alu_q.tag <= alu_result.tag;
		// spare function codes complete with zero
		alu_q.value <= alu_done ? alu_result.value : '0;
	end

	// multiply takes port a, ALU result slides to port b
	assign wr_a   = mult_done || alu_q_valid;
	assign data_a = mult_done ? mult_result : alu_q;
	assign wr_b   = mult_done && alu_q_valid;
	assign data_b = alu_q;

	////////////////////////////////////////
	// bus credits and drain
	////////////////////////////////////////
	assign pop = head_valid && (bus_cnt != '0);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			bus_cnt <= CNT_W'(BUS_CREDITS);
		end else begin
			bus_cnt <= bus_cnt + {{(CNT_W-1){1'b0}}, bus_credit}
				- {{(CNT_W-1){1'b0}}, pop};
		end
	end

	// each drained slot goes back to the issuer
	assign issue_credit   = pop;
	assign complete_valid = pop;

endmodule

//--- ex_pkg.sv
// execute stage datapath definitions
// widths, queue depths, credit counts and the records
// passed between the execute blocks
package ex_pkg;

	localparam int XLEN        = 32;
	localparam int SHAMT_W     = 5;
	localparam int TAG_W       = 6;
	localparam int MULT_STAGES = 4;
	// multiplier bits consumed per stage
	localparam int MULT_CHUNK  = (2 * XLEN) / MULT_STAGES;
	// one issue credit per slot
	localparam int BUF_DEPTH   = 8;
	localparam int BUS_CREDITS = 2;
	localparam int CNT_W       = 4;

	////////////////////////////////////////
	// records
	////////////////////////////////////////

	// operation as handed over by the issuer
	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [XLEN-1:0]     rs1_value;
		logic [XLEN-1:0]     rs2_value;
		logic [XLEN-1:0]     pc;
		logic [XLEN-1:0]     npc;
		isa_pkg::inst_t      inst;
		isa_pkg::alu_func_t  alu_func;
		isa_pkg::opa_sel_t   opa_sel;
		isa_pkg::opb_sel_t   opb_sel;
		logic                cond_branch;
		logic                uncond_branch;
		logic                predicted_taken;
		logic [XLEN-1:0]     predicted_target;
	} issue_pkt_t;

	// finished value for the result bus
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  value;
	} result_t;

	// resolved branch for the reorder buffer
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic             taken;
		logic             mispredict;
		logic [XLEN-1:0]  target;
	} branch_rec_t;

endpackage

//--- ex_stage.f
isa_pkg.sv
ex_pkg.sv
operand_select.sv
int_alu.sv
branch_resolve.sv
mult_pipeline.sv
completion_buffer.sv
ex_control.sv
ex_stage.sv
ex_stage_assertions.sv
tb_ex_stage.sv

//--- ex_stage.sv
// single-issue integer execute stage
// ALU and branch resolution in one cycle, multiplies through
// the pipelined multiplier, results drained from the completion
// buffer under bus credits
module ex_stage (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                issue_valid,
	input  ex_pkg::issue_pkt_t  issue_pkt,
	output logic                issue_credit,
	output logic                complete_valid,
	output ex_pkg::result_t     complete,
	input  logic                bus_credit,
	output logic                branch_valid,
	output ex_pkg::branch_rec_t branch
);
	import ex_pkg::*;
	import isa_pkg::*;

	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic [XLEN-1:0] alu_out;
	logic            is_mult;
	logic            alu_done;
	result_t         alu_result;
	logic            mult_done;
	result_t         mult_result;
	branch_rec_t     branch_next;
	logic            wr_a;
	logic            wr_b;
	result_t         data_a;
	result_t         data_b;
	logic            pop;
	logic            head_valid;

	assign is_mult = issue_pkt.alu_func inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
	// one of the ten ALU functions
	assign alu_done = issue_pkt.alu_func inside {[ALU_ADD:ALU_SRA]};

	operand_select u_operand_select (
		.issue_pkt (issue_pkt),
		.opa       (opa),
		.opb       (opb)
	);

	int_alu u_int_alu (
		.opa    (opa),
		.opb    (opb),
		.func   (issue_pkt.alu_func),
		.result (alu_out)
	);

	// jumps write the link address
	assign alu_result.tag   = issue_pkt.tag;
	assign alu_result.value = issue_pkt.uncond_branch ? issue_pkt.npc : alu_out;

	branch_resolve u_branch_resolve (
		.issue_pkt  (issue_pkt),
		.alu_result (alu_out),
		.branch     (branch_next)
	);

	mult_pipeline u_mult_pipeline (
		.clock  (clock),
		.rst_n  (rst_n),
		.start  (issue_valid && is_mult),
		.mcand  (issue_pkt.rs1_value),
		.mplier (issue_pkt.rs2_value),
		.func   (issue_pkt.alu_func),
		.tag    (issue_pkt.tag),
		.done   (mult_done),
		.result (mult_result)
	);

	ex_control u_ex_control (
		.clock          (clock),
		.rst_n          (rst_n),
		.issue_valid    (issue_valid),
		.issue_is_mult  (is_mult),
		.alu_done       (alu_done),
		.alu_result     (alu_result),
		.mult_done      (mult_done),
		.mult_result    (mult_result),
		.head_valid     (head_valid),
		.bus_credit     (bus_credit),
		.wr_a           (wr_a),
		.data_a         (data_a),
		.wr_b           (wr_b),
		.data_b         (data_b),
		.pop            (pop),
		.issue_credit   (issue_credit),
		.complete_valid (complete_valid)
	);

	completion_buffer u_completion_buffer (
		.clock      (clock),
		.rst_n      (rst_n),
		.wr_a       (wr_a),
		.data_a     (data_a),
		.wr_b       (wr_b),
		.data_b     (data_b),
		.pop        (pop),
		.head_valid (head_valid),
		.head       (complete)
	);

	////////////////////////////////////////
	// branch record to the reorder buffer
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			branch_valid <= 1'b0;
		end else begin
			branch_valid <= issue_valid && (issue_pkt.cond_branch || issue_pkt.uncond_branch);
		end
	end

	always_ff @(posedge clock) begin
		branch <= branch_next;
	end

endmodule

//--- ex_stage_assertions.sv
// checker for the integer execute stage
// a reference model keyed by tag predicts every result and
// branch record; concurrent checks compare the stage to it
module ex_stage_assertions (
	input logic                clock,
	input logic                rst_n,
	input logic                issue_valid,
	input ex_pkg::issue_pkt_t  issue_pkt,
	input logic                issue_credit,
	input logic                complete_valid,
	input ex_pkg::result_t     complete,
	input logic                bus_credit,
	input logic                branch_valid,
	input ex_pkg::branch_rec_t branch
);
	timeunit 1ns;
	timeprecision 1ps;
	import ex_pkg::*;
	import isa_pkg::*;

	logic [XLEN-1:0] exp_value [2**TAG_W];
	logic            pending   [2**TAG_W];
	branch_rec_t     exp_branch;
	logic [XLEN-1:0] head_expected;
	logic            head_pending;
	logic            issue_pending;
	int              bus_cnt;
	int              outstanding;
	int              fail_count = 0;

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic logic [XLEN-1:0] operand_a(input issue_pkt_t p);
		case (p.opa_sel)
			OPA_IS_RS1: return p.rs1_value;
			OPA_IS_NPC: return p.npc;
			OPA_IS_PC:  return p.pc;
			default:    return '0;
		endcase
	endfunction

	// immediates straight from the instruction bit positions
	function automatic logic [XLEN-1:0] operand_b(input issue_pkt_t p);
		logic [31:0] w;
		w = p.inst;
		case (p.opb_sel)
			OPB_IS_RS2:   return p.rs2_value;
			OPB_IS_I_IMM: return {{20{w[31]}}, w[31:20]};
			OPB_IS_S_IMM: return {{20{w[31]}}, w[31:25], w[11:7]};
			OPB_IS_B_IMM: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			OPB_IS_U_IMM: return {w[31:12], 12'b0};
			OPB_IS_J_IMM: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:      return '0;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] alu_ref(input alu_func_t f, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		case (f)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
			default:  return '0;
		endcase
	endfunction

	// full 64-bit product with signedness per function
	function automatic logic [XLEN-1:0] mul_ref(input alu_func_t f, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		logic signed [2*XLEN-1:0] prod;
		case (f)
			ALU_MUL:    prod = $signed(a) * $signed(b);
			ALU_MULH:   prod = $signed(a) * $signed(b);
			ALU_MULHSU: prod = $signed(a) * $signed({1'b0, b});
			default:    prod = {32'b0, a} * {32'b0, b};
		endcase
		return (f == ALU_MUL) ? prod[31:0] : prod[63:32];
	endfunction

	function automatic logic [XLEN-1:0] expected_value(input issue_pkt_t p);
		if (p.alu_func inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU}) begin
			return mul_ref(p.alu_func, p.rs1_value, p.rs2_value);
		end
		if (p.uncond_branch) begin
			return p.npc;
		end
		return alu_ref(p.alu_func, operand_a(p), operand_b(p));
	endfunction

	function automatic branch_rec_t branch_ref(input issue_pkt_t p);
		branch_rec_t     r;
		logic [XLEN-1:0] t;
		logic [31:0]     w;
		logic            c;
		w = p.inst;
		t = alu_ref(p.alu_func, operand_a(p), operand_b(p));
		case (w[14:12])
			BR_BEQ:  c = p.rs1_value == p.rs2_value;
			BR_BNE:  c = p.rs1_value != p.rs2_value;
			BR_BLT:  c = $signed(p.rs1_value) < $signed(p.rs2_value);
			BR_BGE:  c = $signed(p.rs1_value) >= $signed(p.rs2_value);
			BR_BLTU: c = p.rs1_value < p.rs2_value;
			BR_BGEU: c = p.rs1_value >= p.rs2_value;
			default: c = 1'b0;
		endcase
		r.tag = p.tag;
		if (p.uncond_branch) begin
			r.taken      = 1'b1;
			r.target     = t;
			r.mispredict = t != p.predicted_target;
		end else begin
			r.taken      = c;
			r.target     = c ? t : p.npc;
			r.mispredict = p.predicted_taken ^ c;
		end
		return r;
	endfunction

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int t = 0; t < 2**TAG_W; t++) begin
				pending[t] <= 1'b0;
			end
			bus_cnt     <= BUS_CREDITS;
			outstanding <= 0;
		end else begin
			if (complete_valid) begin
				pending[complete.tag] <= 1'b0;
			end
			if (issue_valid) begin
				pending[issue_pkt.tag]   <= 1'b1;
				exp_value[issue_pkt.tag] <= expected_value(issue_pkt);
			end
			bus_cnt     <= bus_cnt + int'(bus_credit) - int'(complete_valid);
			outstanding <= outstanding + int'(issue_valid) - int'(issue_credit);
		end
	end

	always_ff @(posedge clock) begin
		exp_branch <= branch_ref(issue_pkt);
	end

	assign head_expected = exp_value[complete.tag];
	assign head_pending  = pending[complete.tag];
	assign issue_pending = pending[issue_pkt.tag];

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	value_matches: assert property (@(posedge clock) disable iff (!rst_n)
		complete_valid |-> complete.value == head_expected)
		else begin
			$error("FAIL at %0t: complete.value for tag %0d expected %h got %h", $time,
				$sampled(complete.tag), $sampled(head_expected), $sampled(complete.value));
			fail_count++;
		end

	tag_completes_once: assert property (@(posedge clock) disable iff (!rst_n)
		complete_valid |-> head_pending)
		else begin
			$error("FAIL at %0t: pending flag of complete.tag %0d expected 1 got 0", $time,
				$sampled(complete.tag));
			fail_count++;
		end

	tag_unique_at_issue: assert property (@(posedge clock) disable iff (!rst_n)
		issue_valid |-> !issue_pending)
		else begin
			$error("FAIL at %0t: pending flag of issue_pkt.tag %0d expected 0 got 1", $time,
				$sampled(issue_pkt.tag));
			fail_count++;
		end

	pop_has_bus_credit: assert property (@(posedge clock) disable iff (!rst_n)
		complete_valid |-> bus_cnt != 0)
		else begin
			$error("FAIL at %0t: bus credit count expected above 0 got %0d", $time,
				$sampled(bus_cnt));
			fail_count++;
		end

	// more credits back than issued shows up as a negative count
	credits_bounded: assert property (@(posedge clock) disable iff (!rst_n)
		outstanding >= 0 && outstanding <= BUF_DEPTH)
		else begin
			$error("FAIL at %0t: outstanding issue credits expected 0 to %0d got %0d",
				$time, BUF_DEPTH, $sampled(outstanding));
			fail_count++;
		end

	// record checked one cycle after the issue edge
	branch_matches: assert property (@(posedge clock) disable iff (!rst_n)
		issue_valid && (issue_pkt.cond_branch || issue_pkt.uncond_branch)
		|=> branch_valid && branch == exp_branch)
		else begin
			$error("FAIL at %0t: branch expected valid 1 record %h got valid %b record %h",
				$time, $sampled(exp_branch), $sampled(branch_valid), $sampled(branch));
			fail_count++;
		end

	quiet_in_reset: assert property (@(posedge clock)
		(!rst_n || !$past(rst_n)) |-> !complete_valid && !branch_valid && !issue_credit)
		else begin
			$error("FAIL at %0t: complete_valid branch_valid issue_credit expected 000 got %b%b%b",
				$time, $sampled(complete_valid), $sampled(branch_valid),
				$sampled(issue_credit));
			fail_count++;
		end

endmodule

//--- int_alu.sv
// integer ALU, purely combinational
// ten single-cycle functions; multiplies go elsewhere
module int_alu (
	input  logic [ex_pkg::XLEN-1:0] opa,
	input  logic [ex_pkg::XLEN-1:0] opb,
	input  isa_pkg::alu_func_t      func,
	output logic [ex_pkg::XLEN-1:0] result
);
	import ex_pkg::*;
	import isa_pkg::*;

	logic signed [XLEN-1:0] sopa;
	logic signed [XLEN-1:0] sopb;
	logic [SHAMT_W-1:0]     shamt;

	assign sopa  = opa;
	assign sopb  = opb;
	assign shamt = opb[SHAMT_W-1:0];

	always_comb begin
		case (func)
			ALU_ADD:  result = opa + opb;
			ALU_SUB:  result = opa - opb;
			ALU_AND:  result = opa & opb;
			ALU_OR:   result = opa | opb;
			ALU_XOR:  result = opa ^ opb;
			// set-less-than gives 0 or 1
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, sopa < sopb};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, opa < opb};
			ALU_SLL:  result = opa << shamt;
			ALU_SRL:  result = opa >> shamt;
			ALU_SRA:  result = sopa >>> shamt;
			// mul codes and spare encodings
			default:  result = '0;
		endcase
	end

endmodule

//--- isa_pkg.sv
// isa definitions for the integer execute stage
// instruction formats, the decoded instruction word,
// function and operand-select codes, branch conditions
package isa_pkg;

	// one struct per instruction format, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// same 32-bit word, read per format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_t;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_AND    = 4'h2,
		ALU_OR     = 4'h3,
		ALU_XOR    = 4'h4,
		ALU_SLT    = 4'h5,
		ALU_SLTU   = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha,
		ALU_MULH   = 4'hb,
		ALU_MULHSU = 4'hc,
		ALU_MULHU  = 4'hd
	} alu_func_t;

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_NPC  = 2'h1,
		OPA_IS_PC   = 2'h2,
		OPA_IS_ZERO = 2'h3
	} opa_sel_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} opb_sel_t;

	// conditional branch funct3
	localparam logic [2:0] BR_BEQ  = 3'b000;
	localparam logic [2:0] BR_BNE  = 3'b001;
	localparam logic [2:0] BR_BLT  = 3'b100;
	localparam logic [2:0] BR_BGE  = 3'b101;
	localparam logic [2:0] BR_BLTU = 3'b110;
	localparam logic [2:0] BR_BGEU = 3'b111;

endpackage

//--- mult_pipeline.sv
// pipelined multiplier
// each stage adds one chunk of the multiplier into the running
// product; tag and function ride along with the valid bit
module mult_pipeline (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic [ex_pkg::XLEN-1:0]  mcand,
	input  logic [ex_pkg::XLEN-1:0]  mplier,
	input  isa_pkg::alu_func_t       func,
	input  logic [ex_pkg::TAG_W-1:0] tag,
	output logic                     done,
	output ex_pkg::result_t          result
);
	import ex_pkg::*;
	import isa_pkg::*;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		alu_func_t         func;
		logic [2*XLEN-1:0] product;
		logic [2*XLEN-1:0] mcand;
		logic [2*XLEN-1:0] mplier;
	} mult_stage_t;

	mult_stage_t stg [MULT_STAGES+1];
	logic        vld [MULT_STAGES+1];
	logic        mcand_signed;
	logic        mplier_signed;

	// MULHSU takes rs1 signed and rs2 unsigned
	assign mcand_signed  = func != ALU_MULHU;
	assign mplier_signed = (func == ALU_MUL) || (func == ALU_MULH);

	assign vld[0]         = start;
	assign stg[0].tag     = tag;
	assign stg[0].func    = func;
	assign stg[0].product = '0;
	assign stg[0].mcand   = {{XLEN{mcand_signed & mcand[XLEN-1]}}, mcand};
	assign stg[0].mplier  = {{XLEN{mplier_signed & mplier[XLEN-1]}}, mplier};

	////////////////////////////////////////
	// stage registers
	////////////////////////////////////////
	for (genvar s = 0; s < MULT_STAGES; s++) begin : g_stage
		logic [2*XLEN-1:0] partial;

		// low chunk times the shifted multiplicand, mod 2^(2*XLEN)
		assign partial = stg[s].mplier[MULT_CHUNK-1:0] * stg[s].mcand;

		always_ff @(posedge clock or negedge rst_n) begin
			if (!rst_n) begin
				vld[s+1] <= 1'b0;
			end else begin
				vld[s+1] <= vld[s];
			end
		end

		always_ff @(posedge clock) begin
			stg[s+1].tag     <= stg[s].tag;
			stg[s+1].func    <= stg[s].func;
			stg[s+1].product <= stg[s].product + partial;
			stg[s+1].mcand   <= stg[s].mcand << MULT_CHUNK;
			stg[s+1].mplier  <= stg[s].mplier >> MULT_CHUNK;
		end
	end

	assign done       = vld[MULT_STAGES];
	assign result.tag = stg[MULT_STAGES].tag;
	// MUL keeps the low word, the MULH variants the high word
	assign result.value = (stg[MULT_STAGES].func == ALU_MUL) ?
		stg[MULT_STAGES].product[XLEN-1:0] : stg[MULT_STAGES].product[2*XLEN-1:XLEN];

endmodule

//--- operand_select.sv
// operand muxes in front of the ALU
// operand A from rs1, pc, npc or zero; operand B from rs2
// or one of the sign-extended immediates
module operand_select (
	input  ex_pkg::issue_pkt_t          issue_pkt,
	output logic [ex_pkg::XLEN-1:0]     opa,
	output logic [ex_pkg::XLEN-1:0]     opb
);
	import ex_pkg::*;
	import isa_pkg::*;

	inst_t           inst;
	logic [XLEN-1:0] i_imm;
	logic [XLEN-1:0] s_imm;
	logic [XLEN-1:0] b_imm;
	logic [XLEN-1:0] u_imm;
	logic [XLEN-1:0] j_imm;

	assign inst = issue_pkt.inst;

	// immediates, each through its own format
	assign i_imm = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
	assign s_imm = {{(XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	assign b_imm = {{(XLEN-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
		inst.b.imm10_5, inst.b.imm4_1, 1'b0};
	// upper immediate, low bits zero
	assign u_imm = {inst.u.imm, {(XLEN-20){1'b0}}};
	assign j_imm = {{(XLEN-21){inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
		inst.j.imm11, inst.j.imm10_1, 1'b0};

	always_comb begin
		case (issue_pkt.opa_sel)
			OPA_IS_RS1: opa = issue_pkt.rs1_value;
			OPA_IS_NPC: opa = issue_pkt.npc;
			OPA_IS_PC:  opa = issue_pkt.pc;
			default:    opa = '0;
		endcase
	end

	always_comb begin
		case (issue_pkt.opb_sel)
			OPB_IS_RS2:   opb = issue_pkt.rs2_value;
			OPB_IS_I_IMM: opb = i_imm;
			OPB_IS_S_IMM: opb = s_imm;
			OPB_IS_B_IMM: opb = b_imm;
			OPB_IS_U_IMM: opb = u_imm;
			OPB_IS_J_IMM: opb = j_imm;
			// unused encodings
			default:      opb = '0;
		endcase
	end

endmodule

//--- tb_ex_stage.sv
// testbench for the integer execute stage
// random operations under issue credits, bus credits handed
// back at random; the bound checker does the comparing
module tb_ex_stage;
	timeunit 1ns;
	timeprecision 1ps;
	import ex_pkg::*;
	import isa_pkg::*;

	localparam int NUM_OPS    = 400;
	localparam int WAIT_LIMIT = 500;

	logic             clock;
	logic             rst_n;
	logic             issue_valid;
	issue_pkt_t       issue_pkt;
	logic             issue_credit;
	logic             complete_valid;
	result_t          complete;
	logic             bus_credit;
	logic             branch_valid;
	branch_rec_t      branch;
	logic [31:0]      lcg_state;
	int               credits;
	int               credit_seen;
	int               bus_owed;
	int               issued;
	logic [TAG_W-1:0] next_tag;

	bind ex_stage ex_stage_assertions u_ex_stage_assertions (.*);

	ex_stage u_ex_stage (
		.clock          (clock),
		.rst_n          (rst_n),
		.issue_valid    (issue_valid),
		.issue_pkt      (issue_pkt),
		.issue_credit   (issue_credit),
		.complete_valid (complete_valid),
		.complete       (complete),
		.bus_credit     (bus_credit),
		.branch_valid   (branch_valid),
		.branch         (branch)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic logic [31:0] rand32();
		logic [15:0] hi;
		hi = rand16();
		return {hi, rand16()};
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("Test failed");
		$fatal(1, reason);
	endtask

	// one clock, then bookkeeping and the bus side
	task automatic tick();
		int speed;
		@(posedge clock);
		#1;
		if (u_ex_stage.u_ex_stage_assertions.fail_count != 0) begin
			stop_with_failure("an assertion on the execute stage failed");
		end
		issue_valid = 1'b0;
		// pulses from last cycle are usable now
		credits     = credits + credit_seen;
		credit_seen = int'(issue_credit);
		bus_owed    = bus_owed + int'(complete_valid);
		// slow and fast bus phases
		speed = ((issued / 50) % 2 == 0) ? 1 : 4;
		bus_credit = 1'b0;
		if (bus_owed > 0 && int'(rand16() % 4) < speed) begin
			bus_credit = 1'b1;
			bus_owed--;
		end
	endtask

	task automatic build_op(output issue_pkt_t p);
		logic [15:0] kind;
		logic [2:0]  f3;
		p           = '0;
		p.tag       = next_tag;
		p.rs1_value = rand32();
		// equal operands now and then for the compares
		p.rs2_value        = (rand16() % 4 == 0) ? p.rs1_value : rand32();
		p.pc               = rand32() & ~32'h3;
		p.npc              = p.pc + 32'd4;
		p.inst             = rand32();
		p.predicted_taken  = (rand16() & 16'h1) != 0;
		p.predicted_target = rand32() & ~32'h3;
		kind               = rand16() % 8;
		if (kind == 0) begin
			f3 = 3'(rand16() % 8);
			if (f3 == 3'b010 || f3 == 3'b011) begin
				f3 = BR_BEQ;
			end
			p.inst.b.funct3 = f3;
			p.cond_branch   = 1'b1;
			p.alu_func      = ALU_ADD;
			p.opa_sel       = OPA_IS_PC;
			p.opb_sel       = OPB_IS_B_IMM;
		end else if (kind == 1) begin
			p.uncond_branch = 1'b1;
			p.alu_func      = ALU_ADD;
			// jal or jalr style target
			if (rand16() % 2 == 0) begin
				p.opa_sel = OPA_IS_PC;
				p.opb_sel = OPB_IS_J_IMM;
			end else begin
				p.opa_sel = OPA_IS_RS1;
				p.opb_sel = OPB_IS_I_IMM;
			end
		end else begin
			p.alu_func = alu_func_t'(4'(rand16() % 14));
			p.opa_sel  = opa_sel_t'(2'(rand16() % 4));
			p.opb_sel  = opb_sel_t'(3'(rand16() % 6));
		end
	endtask

	initial begin
		issue_pkt_t pkt;
		int         waited;
		lcg_state   = 32'd43801;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue_pkt   = '0;
		bus_credit  = 1'b0;
		credits     = BUF_DEPTH;
		credit_seen = 0;
		bus_owed    = 0;
		issued      = 0;
		next_tag    = '0;
		repeat (3) begin
			@(posedge clock);
		end
		#1;
		rst_n  = 1'b1;
		waited = 0;
		while (issued < NUM_OPS) begin
			tick();
			if (credits == 0) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					stop_with_failure("timed out waiting for an issue credit");
				end
			end else if (rand16() % 4 != 0) begin
				build_op(pkt);
				issue_pkt   = pkt;
				issue_valid = 1'b1;
				credits--;
				issued++;
				next_tag++;
				waited = 0;
			end
		end
		// drain until every slot has been paid back
		waited = 0;
		while (credits + credit_seen != BUF_DEPTH && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		repeat (2) begin
			tick();
		end
		if (credits == BUF_DEPTH) begin
			$display("Test passed");
			$finish;
		end else begin
			stop_with_failure("timed out waiting for the buffer to drain");
		end
	end

endmodule
